// ==== cpu_consts.svh ====
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// datapath and program address widths
`define NIBBLE_W 4
`define ADDR_W 12
`define NUM_REGS 16

// machine cycle timing
`define SUBCYCLES 8
`define SC_STACK 2
`define SC_FETCH_HI 3
`define SC_FETCH_LO 4
`define SC_EXEC 5
`define SC_LAST 7
`define STACK_DEPTH 3

`endif

// ==== cpu_types_pkg.sv ====
`default_nettype none

`include "cpu_consts.svh"

package cpu_types_pkg;

    typedef logic [`NIBBLE_W-1:0] nibble_t;
    typedef logic [`ADDR_W-1:0] addr_t;
    typedef logic [$clog2(`SUBCYCLES)-1:0] subcycle_t;

    typedef enum logic [1:0] {alu_add, alu_pass, alu_rol, alu_ror} alu_op_t;

    // first ALU operand, optionally inverted for SUB and CMA
    typedef enum logic [1:0] {in0_reg, in0_reg_inv, in0_acc, in0_acc_inv} alu_in0_sel_t;
    typedef enum logic [1:0] {in1_zero, in1_acc, in1_one} alu_in1_sel_t;
    typedef enum logic [1:0] {cin_zero, cin_carry, cin_carry_inv, cin_one} alu_cin_sel_t;

    // accumulator and register write sources
    typedef enum logic [1:0] {acc_from_alu, acc_from_reg, acc_from_imm} acc_sel_t;
    typedef enum logic {reg_from_alu, reg_from_acc} reg_sel_t;

    typedef enum logic [1:0] {stack_none, stack_push, stack_pop} stack_op_t;

endpackage

`default_nettype wire

// ==== isa_pkg.sv ====
`default_nettype none

package isa_pkg;

    // high nibble of the instruction word
    typedef enum logic [3:0] {
        op_nop = 4'h0,
        op_jun = 4'h4,
        op_jms = 4'h5,
        op_inc = 4'h6,
        op_add = 4'h8,
        op_sub = 4'h9,
        op_ld  = 4'ha,
        op_xch = 4'hb,
        op_bbl = 4'hc,
        op_ldm = 4'hd,
        op_acc = 4'hf
    } opcode_t;

    // low nibble selects the operation within op_acc
    typedef enum logic [3:0] {
        acc_clb = 4'h0,
        acc_clc = 4'h1,
        acc_iac = 4'h2,
        acc_cmc = 4'h3,
        acc_cma = 4'h4,
        acc_ral = 4'h5,
        acc_rar = 4'h6,
        acc_stc = 4'ha
    } acc_group_t;

    typedef struct packed {
        opcode_t opr;
        cpu_types_pkg::nibble_t opa;
    } inst_t;

endpackage

`default_nettype wire

// ==== ctrl_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface ctrl_if;
    import cpu_types_pkg::*;

    // single-subcycle strobes, acted on at the edge ending that subcycle
    logic write_acc;
    logic clear_acc;
    logic write_carry;
    logic clear_carry;
    logic write_reg;

    acc_sel_t acc_sel;
    reg_sel_t reg_sel;
    alu_op_t alu_op;
    alu_in0_sel_t in0_sel;
    alu_in1_sel_t in1_sel;
    alu_cin_sel_t cin_sel;

    modport decoder (
        output write_acc, clear_acc, acc_sel,
        output write_carry, clear_carry,
        output write_reg, reg_sel,
        output alu_op, in0_sel, in1_sel, cin_sel
    );

    modport datapath (
        input write_acc, clear_acc, acc_sel,
        input write_carry, clear_carry,
        input write_reg, reg_sel,
        input alu_op, in0_sel, in1_sel, cin_sel
    );

endinterface

`default_nettype wire

// ==== alu.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cpu_consts.svh"

module alu (
    input  wire cpu_types_pkg::alu_op_t op,
    input  wire cpu_types_pkg::nibble_t in0,
    input  wire cpu_types_pkg::nibble_t in1,
    input  wire                        cin,
    output cpu_types_pkg::nibble_t     result,
    output logic                       cout
);
    import cpu_types_pkg::*;

    logic [`NIBBLE_W:0] sum;

    assign sum = {1'b0, in0} + {1'b0, in1} + {{`NIBBLE_W{1'b0}}, cin};

    always_comb begin
        result = in0;
        cout = cin;
        case (op)
            alu_add: {cout, result} = sum;
            alu_rol: begin
                result = {in0[`NIBBLE_W-2:0], cin};
                cout = in0[`NIBBLE_W-1];
            end
            alu_ror: begin
                result = {cin, in0[`NIBBLE_W-1:1]};
                cout = in0[0];
            end
            // pass keeps the defaults
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== fetch_sequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cpu_consts.svh"

module fetch_sequencer (
    input  wire                        clock,
    input  wire                        reset,
    input  wire cpu_types_pkg::nibble_t rom_data,
    input  wire                        two_word,
    output cpu_types_pkg::subcycle_t   subcycle,
    output logic                       sync,
    output isa_pkg::inst_t             inst
);
    import cpu_types_pkg::*;
    import isa_pkg::*;

    always_ff @(posedge clock) begin
        if (reset) begin
            subcycle <= '0;
        end else if (subcycle == `SC_LAST) begin
            subcycle <= '0;
        end else begin
            subcycle <= subcycle + 1'b1;
        end
    end

    // active low, marks the last subcycle of every machine cycle
    assign sync = (subcycle != `SC_LAST);

    // the second word of JUN/JMS is an address, so inst keeps the opcode
    always_ff @(posedge clock) begin
        if (reset) begin
            inst <= '{opr: op_nop, opa: '0};
        end else if (!two_word) begin
            if (subcycle == `SC_FETCH_HI) begin
                inst.opr <= opcode_t'(rom_data);
            end else if (subcycle == `SC_FETCH_LO) begin
                inst.opa <= rom_data;
            end
        end
    end

endmodule

`default_nettype wire

// ==== instruction_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cpu_consts.svh"

module instruction_decoder (
    input  wire                          clock,
    input  wire                          reset,
    input  wire cpu_types_pkg::subcycle_t subcycle,
    input  wire isa_pkg::inst_t          inst,
    output logic                         two_word,
    output cpu_types_pkg::nibble_t       operand,
    output logic [2:0]                   nibble_write,
    output cpu_types_pkg::stack_op_t     stack_op,
    ctrl_if.decoder                      ctrl
);
    import cpu_types_pkg::*;
    import isa_pkg::*;

    logic two_word_next;
    logic exec;

    assign operand = inst.opa;
    assign exec = (subcycle == `SC_EXEC);

    always_comb begin
        ctrl.write_acc = 1'b0;
        ctrl.clear_acc = 1'b0;
        ctrl.acc_sel = acc_from_alu;
        ctrl.write_carry = 1'b0;
        ctrl.clear_carry = 1'b0;
        ctrl.write_reg = 1'b0;
        ctrl.reg_sel = reg_from_alu;
        ctrl.alu_op = alu_add;
        ctrl.in0_sel = in0_acc;
        ctrl.in1_sel = in1_zero;
        ctrl.cin_sel = cin_zero;
        nibble_write = 3'b000;
        stack_op = stack_none;
        two_word_next = two_word;

        if (two_word) begin
            // in the second machine cycle of JUN/JMS the data carries the target address
            if (exec) begin
                two_word_next = 1'b0;
            end
            case (subcycle)
                `SC_FETCH_HI: nibble_write = 3'b010;
                `SC_FETCH_LO: nibble_write = 3'b001;
                `SC_EXEC:     nibble_write = 3'b100;
                default:      nibble_write = 3'b000;
            endcase
            if (inst.opr == op_jms && subcycle == `SC_STACK) begin
                stack_op = stack_push;
            end
        end else begin
            // inst still holds BBL in subcycle 2 of the following machine cycle
            if (inst.opr == op_bbl && subcycle == `SC_STACK) begin
                stack_op = stack_pop;
            end
            if (exec) begin
                case (inst.opr)
                    op_jun, op_jms: two_word_next = 1'b1;
                    op_inc: begin
                        // carry is left alone
                        ctrl.in0_sel = in0_reg;
                        ctrl.in1_sel = in1_one;
                        ctrl.write_reg = 1'b1;
                    end
                    op_add, op_sub: begin
                        ctrl.in0_sel = (inst.opr == op_sub) ? in0_reg_inv : in0_reg;
                        ctrl.in1_sel = in1_acc;
                        ctrl.cin_sel = (inst.opr == op_sub) ? cin_carry_inv : cin_carry;
                        ctrl.write_acc = 1'b1;
                        ctrl.write_carry = 1'b1;
                    end
                    op_ld: begin
                        ctrl.acc_sel = acc_from_reg;
                        ctrl.write_acc = 1'b1;
                    end
                    op_xch: begin
                        ctrl.acc_sel = acc_from_reg;
                        ctrl.write_acc = 1'b1;
                        ctrl.reg_sel = reg_from_acc;
                        ctrl.write_reg = 1'b1;
                    end
                    op_bbl, op_ldm: begin
                        ctrl.acc_sel = acc_from_imm;
                        ctrl.write_acc = 1'b1;
                    end
                    op_acc: begin
                        case (acc_group_t'(inst.opa))
                            acc_clb: begin
                                ctrl.clear_acc = 1'b1;
                                ctrl.clear_carry = 1'b1;
                            end
                            acc_clc: ctrl.clear_carry = 1'b1;
                            acc_iac: begin
                                ctrl.in1_sel = in1_one;
                                ctrl.write_acc = 1'b1;
                                ctrl.write_carry = 1'b1;
                            end
                            acc_cmc, acc_stc: begin
                                ctrl.alu_op = alu_pass;
                                ctrl.cin_sel = (inst.opa == acc_stc) ? cin_one : cin_carry_inv;
                                ctrl.write_carry = 1'b1;
                            end
                            acc_cma: begin
                                ctrl.alu_op = alu_pass;
                                ctrl.in0_sel = in0_acc_inv;
                                ctrl.write_acc = 1'b1;
                            end
                            acc_ral, acc_rar: begin
                                // rotate through carry
                                ctrl.alu_op = (inst.opa == acc_ral) ? alu_rol : alu_ror;
                                ctrl.cin_sel = cin_carry;
                                ctrl.write_acc = 1'b1;
                                ctrl.write_carry = 1'b1;
                            end
                            default: ;
                        endcase
                    end
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            two_word <= 1'b0;
        end else begin
            two_word <= two_word_next;
        end
    end

endmodule

`default_nettype wire

// ==== datapath.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cpu_consts.svh"

module datapath (
    input  wire                        clock,
    input  wire                        reset,
    input  wire cpu_types_pkg::nibble_t operand,
    ctrl_if.datapath                   ctrl,
    output cpu_types_pkg::nibble_t     acc,
    output logic                       carry
);
    import cpu_types_pkg::*;

    nibble_t regs [`NUM_REGS];
    nibble_t reg_val;
    nibble_t alu_in0;
    nibble_t alu_in1;
    nibble_t alu_result;
    nibble_t acc_in;
    nibble_t reg_in;
    logic alu_cin;
    logic alu_cout;

    // operand doubles as the register index
    assign reg_val = regs[operand];

    always_comb begin
        case (ctrl.in0_sel)
            in0_reg:     alu_in0 = reg_val;
            in0_reg_inv: alu_in0 = ~reg_val;
            in0_acc_inv: alu_in0 = ~acc;
            default:     alu_in0 = acc;
        endcase
        case (ctrl.in1_sel)
            in1_acc: alu_in1 = acc;
            in1_one: alu_in1 = nibble_t'(1);
            default: alu_in1 = '0;
        endcase
        case (ctrl.cin_sel)
            cin_carry:     alu_cin = carry;
            cin_carry_inv: alu_cin = ~carry;
            cin_one:       alu_cin = 1'b1;
            default:       alu_cin = 1'b0;
        endcase
        case (ctrl.acc_sel)
            acc_from_reg: acc_in = reg_val;
            acc_from_imm: acc_in = operand;
            default:      acc_in = alu_result;
        endcase
        reg_in = (ctrl.reg_sel == reg_from_acc) ? acc : alu_result;
    end

    alu alu_inst (
        .op     (ctrl.alu_op),
        .in0    (alu_in0),
        .in1    (alu_in1),
        .cin    (alu_cin),
        .result (alu_result),
        .cout   (alu_cout)
    );

    // XCH writes both sides from the pre-edge values
    always_ff @(posedge clock) begin
        if (reset) begin
            acc <= '0;
            carry <= 1'b0;
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (ctrl.clear_acc) begin
                acc <= '0;
            end else if (ctrl.write_acc) begin
                acc <= acc_in;
            end
            if (ctrl.clear_carry) begin
                carry <= 1'b0;
            end else if (ctrl.write_carry) begin
                carry <= alu_cout;
            end
            if (ctrl.write_reg) begin
                regs[operand] <= reg_in;
            end
        end
    end

endmodule

`default_nettype wire

// ==== pc_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cpu_consts.svh"

module pc_unit (
    input  wire                          clock,
    input  wire                          reset,
    input  wire cpu_types_pkg::subcycle_t subcycle,
    input  wire cpu_types_pkg::nibble_t  rom_data,
    input  wire cpu_types_pkg::nibble_t  operand,
    input  wire [2:0]                    nibble_write,
    input  wire cpu_types_pkg::stack_op_t stack_op,
    output cpu_types_pkg::addr_t         rom_addr
);
    import cpu_types_pkg::*;

    localparam int sp_w = $clog2(`STACK_DEPTH);

    addr_t pc;
    addr_t pc_inc;
    addr_t target;
    addr_t popped;
    addr_t stack [`STACK_DEPTH];
    logic target_written;
    logic pop_pending;
    logic [sp_w-1:0] sp;
    logic [sp_w-1:0] sp_up;
    logic [sp_w-1:0] sp_down;

    assign rom_addr = pc;
    assign pc_inc = pc + 1'b1;

    // pointer wraps modulo the stack depth
    assign sp_up = (sp == sp_w'(`STACK_DEPTH - 1)) ? '0 : sp + 1'b1;
    assign sp_down = (sp == '0) ? sp_w'(`STACK_DEPTH - 1) : sp - 1'b1;

    always_ff @(posedge clock) begin
        if (nibble_write[1]) target[7:4] <= rom_data;
        if (nibble_write[0]) target[3:0] <= rom_data;
        if (nibble_write[2]) target[11:8] <= operand;
        if (stack_op == stack_push) stack[sp] <= pc_inc;
        if (stack_op == stack_pop) popped <= stack[sp_down];
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= '0;
            sp <= '0;
            target_written <= 1'b0;
            pop_pending <= 1'b0;
        end else begin
            if (stack_op == stack_push) begin
                sp <= sp_up;
            end else if (stack_op == stack_pop) begin
                sp <= sp_down;
                pop_pending <= 1'b1;
            end
            if (|nibble_write) begin
                target_written <= 1'b1;
            end
            // jump target beats return address beats increment
            if (subcycle == `SC_LAST) begin
                pc <= target_written ? target : (pop_pending ? popped : pc_inc);
                target_written <= 1'b0;
                pop_pending <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== cpu_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpu_core (
    input  wire                        clock,
    input  wire                        reset,
    input  wire cpu_types_pkg::nibble_t rom_data,
    output logic                       sync,
    output cpu_types_pkg::addr_t       rom_addr,
    output cpu_types_pkg::nibble_t     acc,
    output logic                       carry
);
    import cpu_types_pkg::*;
    import isa_pkg::*;

    subcycle_t subcycle;
    inst_t inst;
    logic two_word;
    nibble_t operand;
    logic [2:0] nibble_write;
    stack_op_t stack_op;

    ctrl_if ctrl ();

    fetch_sequencer fetch_sequencer_inst (
        .clock    (clock),
        .reset    (reset),
        .rom_data (rom_data),
        .two_word (two_word),
        .subcycle (subcycle),
        .sync     (sync),
        .inst     (inst)
    );

    instruction_decoder instruction_decoder_inst (
        .clock        (clock),
        .reset        (reset),
        .subcycle     (subcycle),
        .inst         (inst),
        .two_word     (two_word),
        .operand      (operand),
        .nibble_write (nibble_write),
        .stack_op     (stack_op),
        .ctrl         (ctrl.decoder)
    );

    datapath datapath_inst (
        .clock   (clock),
        .reset   (reset),
        .operand (operand),
        .ctrl    (ctrl.datapath),
        .acc     (acc),
        .carry   (carry)
    );

    pc_unit pc_unit_inst (
        .clock        (clock),
        .reset        (reset),
        .subcycle     (subcycle),
        .rom_data     (rom_data),
        .operand      (operand),
        .nibble_write (nibble_write),
        .stack_op     (stack_op),
        .rom_addr     (rom_addr)
    );

endmodule

`default_nettype wire

// ==== cpu_core_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpu_core_checker (
    input wire                       clock,
    input wire                       reset,
    input wire                       sync,
    input wire cpu_types_pkg::addr_t rom_addr
);

    // sync marks a single subcycle
    sync_single_clock: assert property (@(posedge clock) disable iff (reset)
        !sync |=> sync)
        else $error("sync low on two consecutive clocks");

    // one machine cycle is eight clocks
    sync_period: assert property (@(posedge clock) disable iff (reset)
        $fell(sync) |=> sync [*7] ##1 !sync)
        else $error("sync fall not eight clocks after the previous fall");

    // the address moves only at the machine cycle boundary
    rom_addr_boundary: assert property (@(posedge clock) disable iff (reset)
        $changed(rom_addr) |-> $past(!sync))
        else $error("rom_addr changed away from the machine cycle boundary");

endmodule

bind cpu_core cpu_core_checker cpu_core_checker_inst (
    .clock    (clock),
    .reset    (reset),
    .sync     (sync),
    .rom_addr (rom_addr)
);

`default_nettype wire

// ==== tb_cpu_core.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cpu_consts.svh"

module tb_cpu_core;
    import cpu_types_pkg::*;
    import isa_pkg::*;

    logic clock;
    logic reset;
    nibble_t rom_data;
    logic sync;
    addr_t rom_addr;
    nibble_t acc;
    logic carry;

    integer seed;
    int errors;
    int checks;
    bit timed_out;
    int prog_ptr;
    logic [2:0] subcycle_now;
    logic [7:0] rom [2**`ADDR_W];

    // reference model state
    nibble_t m_acc;
    logic m_carry;
    nibble_t m_regs [`NUM_REGS];
    addr_t m_pc;
    addr_t m_stack [$];
    logic m_second;
    inst_t m_first;
    logic m_ret;
    addr_t m_ret_addr;

    cpu_core cpu_core_inst (
        .clock    (clock),
        .reset    (reset),
        .rom_data (rom_data),
        .sync     (sync),
        .rom_addr (rom_addr),
        .acc      (acc),
        .carry    (carry)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("ERR %0t: %s is %0h, expected %0h", $time, what, got, expected);
        end
    endtask

    // one falling edge, then present the ROM nibble for the current subcycle
    task automatic step_clock;
        @(negedge clock);
        if (reset) begin
            subcycle_now = '0;
        end else if (!sync) begin
            subcycle_now = 3'd7;
        end else begin
            subcycle_now = subcycle_now + 1'b1;
        end
        if (subcycle_now == `SC_FETCH_HI) begin
            rom_data = rom[rom_addr][7:4];
        end else if (subcycle_now == `SC_FETCH_LO) begin
            rom_data = rom[rom_addr][3:0];
        end else begin
            rom_data = nibble_t'($random(seed));
        end
    endtask

    task automatic wait_sync_low(output int clocks);
        clocks = 0;
        do begin
            step_clock();
            clocks++;
        end while (sync && clocks < 4 * `SUBCYCLES);
        if (sync) begin
            $display("timeout at %0t: sync did not go low within %0d clocks", $time, clocks);
            timed_out = 1'b1;
        end
    endtask

    task automatic clear_rom;
        foreach (rom[a]) begin
            rom[a] = 8'h00;
        end
        prog_ptr = 0;
    endtask

    task automatic emit(input logic [7:0] word);
        rom[prog_ptr] = word;
        prog_ptr++;
    endtask

    task automatic reset_dut;
        reset = 1'b1;
        repeat (3) step_clock();
        reset = 1'b0;
        m_acc = '0;
        m_carry = 1'b0;
        foreach (m_regs[i]) begin
            m_regs[i] = '0;
        end
        m_pc = '0;
        m_stack.delete();
        m_second = 1'b0;
        m_ret = 1'b0;
    endtask

    // executes the word at m_pc by the instruction rules
    task automatic model_step;
        inst_t w;
        addr_t next_pc;
        nibble_t tmp;
        w = rom[m_pc];
        next_pc = m_pc + 1'b1;
        if (m_second) begin
            // second word holds the low eight target bits
            next_pc = {m_first.opa, w};
            if (m_first.opr == op_jms) begin
                m_stack.push_back(m_pc + 1'b1);
            end
            m_second = 1'b0;
        end else begin
            // the word after BBL still executes before the return lands
            if (m_ret) begin
                next_pc = m_ret_addr;
                m_ret = 1'b0;
            end
            case (w.opr)
                op_jun, op_jms: begin
                    m_second = 1'b1;
                    m_first = w;
                end
                op_inc: m_regs[w.opa] = m_regs[w.opa] + 1'b1;
                op_add: {m_carry, m_acc} = m_acc + m_regs[w.opa] + m_carry;
                op_sub: begin
                    tmp = ~m_regs[w.opa];
                    {m_carry, m_acc} = m_acc + tmp + !m_carry;
                end
                op_ld: m_acc = m_regs[w.opa];
                op_xch: begin
                    tmp = m_acc;
                    m_acc = m_regs[w.opa];
                    m_regs[w.opa] = tmp;
                end
                op_bbl: begin
                    m_acc = w.opa;
                    m_ret = 1'b1;
                    m_ret_addr = m_stack.pop_back();
                end
                op_ldm: m_acc = w.opa;
                op_acc: begin
                    case (acc_group_t'(w.opa))
                        acc_clb: begin
                            m_acc = '0;
                            m_carry = 1'b0;
                        end
                        acc_clc: m_carry = 1'b0;
                        acc_iac: {m_carry, m_acc} = m_acc + 1'b1;
                        acc_cmc: m_carry = ~m_carry;
                        acc_cma: m_acc = ~m_acc;
                        acc_ral: {m_carry, m_acc} = {m_acc, m_carry};
                        acc_rar: {m_acc, m_carry} = {m_carry, m_acc};
                        acc_stc: m_carry = 1'b1;
                        default: ;
                    endcase
                end
                default: ;
            endcase
        end
        m_pc = next_pc;
    endtask

    // checks state at every sync low against the model
    task automatic run_cycles(input int count);
        int clocks;
        for (int i = 0; i < count; i++) begin
            wait_sync_low(clocks);
            if (timed_out) begin
                break;
            end
            if (i > 0) begin
                check_value("clocks between sync lows", clocks, `SUBCYCLES);
            end
            check_value("rom_addr", rom_addr, m_pc);
            model_step();
            check_value("acc", acc, m_acc);
            check_value("carry", carry, m_carry);
        end
    endtask

    task automatic test_reset_nops;
        clear_rom();
        reset_dut();
        check_value("rom_addr after reset", rom_addr, 0);
        check_value("acc after reset", acc, 0);
        check_value("carry after reset", carry, 0);
        check_value("sync after reset", sync, 1);
        run_cycles(6);
    endtask

    task automatic test_acc_group;
        nibble_t v;
        v = nibble_t'($random(seed));
        clear_rom();
        emit({op_ldm, v});
        emit({op_acc, acc_iac});
        // 15 plus one wraps and sets carry
        emit({op_ldm, 4'hf});
        emit({op_acc, acc_iac});
        emit({op_acc, acc_cma});
        emit({op_acc, acc_clb});
        emit({op_acc, acc_stc});
        emit({op_acc, acc_cmc});
        emit({op_acc, acc_cmc});
        emit({op_acc, acc_clc});
        emit({op_ldm, v});
        emit({op_acc, acc_cma});
        emit({op_acc, acc_iac});
        reset_dut();
        run_cycles(prog_ptr);
    endtask

    task automatic test_registers;
        nibble_t r1;
        nibble_t r2;
        logic coin;
        clear_rom();
        repeat (4) begin
            r1 = nibble_t'($random(seed));
            r2 = nibble_t'($random(seed));
            coin = $random(seed);
            emit({op_ldm, nibble_t'($random(seed))});
            emit({op_xch, r1});
            emit({op_ldm, nibble_t'($random(seed))});
            emit({op_xch, r2});
            emit({op_ldm, nibble_t'($random(seed))});
            emit({op_acc, coin ? acc_stc : acc_clc});
            emit({op_add, r1});
            emit({op_sub, r2});
            emit({op_sub, r1});
            emit({op_inc, r2});
            emit({op_ld, r2});
            emit({op_xch, r1});
            emit({op_ld, r1});
        end
        reset_dut();
        run_cycles(prog_ptr);
    endtask

    task automatic test_rotates;
        logic coin;
        clear_rom();
        repeat (6) begin
            coin = $random(seed);
            emit({op_ldm, nibble_t'($random(seed))});
            emit({op_acc, coin ? acc_stc : acc_clc});
            emit({op_acc, acc_ral});
            emit({op_acc, acc_ral});
            emit({op_acc, acc_rar});
            emit({op_acc, acc_ral});
            emit({op_acc, acc_rar});
            emit({op_acc, acc_rar});
        end
        reset_dut();
        run_cycles(prog_ptr);
    endtask

    // JUN to 0x5a3, then calls nested two deep through 0x120 and 0x2c0
    task automatic test_jumps;
        clear_rom();
        rom[12'h000] = {op_ldm, 4'h1};
        rom[12'h001] = {op_jun, 4'h5};
        rom[12'h002] = 8'ha3;
        rom[12'h003] = {op_ldm, 4'hf};
        rom[12'h5a3] = {op_ldm, 4'h2};
        rom[12'h5a4] = {op_jms, 4'h1};
        rom[12'h5a5] = 8'h20;
        rom[12'h5a6] = {op_acc, acc_iac};
        rom[12'h120] = {op_ldm, 4'h6};
        rom[12'h121] = {op_jms, 4'h2};
        rom[12'h122] = 8'hc0;
        rom[12'h123] = {op_bbl, 4'h9};
        rom[12'h2c0] = {op_acc, acc_iac};
        rom[12'h2c1] = {op_bbl, 4'h4};
        reset_dut();
        run_cycles(17);
    endtask

    initial begin
        seed = 32'h5c36384b;
        errors = 0;
        checks = 0;
        timed_out = 1'b0;
        reset = 1'b1;
        rom_data = '0;
        subcycle_now = '0;
        test_reset_nops();
        if (!timed_out) test_acc_group();
        if (!timed_out) test_registers();
        if (!timed_out) test_rotates();
        if (!timed_out) test_jumps();
        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+.
cpu_types_pkg.sv
isa_pkg.sv
ctrl_if.sv
alu.sv
fetch_sequencer.sv
instruction_decoder.sv
datapath.sv
pc_unit.sv
cpu_core.sv
cpu_core_checker.sv
tb_cpu_core.sv

// ==== Bender.yml ====
package:
  name: cpu_core

sources:
  - include_dirs:
      - .
    files:
      - cpu_types_pkg.sv
      - isa_pkg.sv
      - ctrl_if.sv
      - alu.sv
      - fetch_sequencer.sv
      - instruction_decoder.sv
      - datapath.sv
      - pc_unit.sv
      - cpu_core.sv
  - target: test
    include_dirs:
      - .
    files:
      - cpu_core_checker.sv
      - tb_cpu_core.sv
